// ==== hw/tlp_hdr_pkg.sv ====
// ==========================================================================
// Only the first 64 bits of a TLP header are described, which is all the
// receive split needs. fmt_type sits in the top byte of requests and completions.
// ==========================================================================
`default_nettype none

package tlp_hdr_pkg;

   // ========================================================================
   // Field widths and format codes
   // ========================================================================

   localparam int HDR_W        = 64;
   localparam int TAG_W        = 10;
   localparam int LEN_W        = 10;
   // Bit 6 of fmt_type is the "with data" bit of the fmt field
   localparam int FMT_DATA_BIT = 6;

   typedef logic [7:0] fmt_type_t;

   localparam fmt_type_t FMT_MRD  = 8'h20;
   localparam fmt_type_t FMT_MWR  = 8'h60;
   localparam fmt_type_t FMT_CPL  = 8'h0a;
   localparam fmt_type_t FMT_CPLD = 8'h4a;

   // First-beat header view, fmt_type on top so that a request decodes the
   // same way and can be told apart from a completion
   typedef struct packed {
      fmt_type_t              fmt_type;
      logic [TAG_W-1:0]       tag;
      logic [LEN_W-1:0]       length;
      logic [HDR_W-8-TAG_W-LEN_W-1:0] rsvd;
   } cpl_hdr_t;

   // ========================================================================
   // Classification helpers
   // ========================================================================

   // True for both Cpl and CplD
   function automatic logic is_completion(input fmt_type_t ft);
      return (ft == FMT_CPL) || (ft == FMT_CPLD);
   endfunction

   // The data bit alone, valid for requests as well as completions
   function automatic logic has_data(input fmt_type_t ft);
      return ft[FMT_DATA_BIT];
   endfunction

endpackage

`default_nettype wire

// ==== hw/rx_chan_pkg.sv ====
// ==========================================================================
// Channel mapping is fixed at compile time. Only one class may sit on RX-B;
// mapping both read completions and write commits to RX-B is not supported.
// ==========================================================================
`default_nettype none

package rx_chan_pkg;

   localparam int NUM_PORTS = 2;

   // The two receive channels coming from the PCIe subsystem
   typedef enum logic {
      CHAN_A = 1'b0,
      CHAN_B = 1'b1
   } chan_t;

   // Read completions arrive on RX-A, write commits on RX-B
   localparam chan_t CPL_CHAN       = CHAN_A;
   localparam chan_t WR_COMMIT_CHAN = CHAN_B;

   localparam int DATA_W = 64;
   localparam int KEEP_W = DATA_W / 8;
   localparam int USER_W = 8;

   // One beat as it travels through the buffers, 81 bits
   typedef struct packed {
      logic              last;
      logic [USER_W-1:0] user;
      logic [DATA_W-1:0] data;
      logic [KEEP_W-1:0] keep;
   } rx_beat_t;

   // A write commit keeps only the tag of the original write and the user
   // bits of its beat
   typedef struct packed {
      logic [tlp_hdr_pkg::TAG_W-1:0] tag;
      logic [USER_W-1:0]             user;
   } commit_t;

endpackage

`default_nettype wire

// ==== hw/rx_skid_buffer.sv ====
// ==========================================================================
// Two entries, one cycle of latency. in_ready comes straight from a flop so
// out_ready never reaches the upstream ready combinationally.
// ==========================================================================
`default_nettype none

module rx_skid_buffer #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     in_valid,
   input  payload_t in_data,
   output logic     in_ready,
   output logic     out_valid,
   output payload_t out_data,
   input  logic     out_ready
);

   // Second entry, only filled when the output is stalled
   logic     skid_valid;
   payload_t skid_data;
   // High when the output register is free to load this cycle
   logic     out_free;

   assign out_free = out_ready || !out_valid;

   // Upstream may push as long as the skid entry is empty
   assign in_ready = !skid_valid;

   // ========================================================================
   // Control state
   // ========================================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid  <= 1'b0;
         skid_valid <= 1'b0;
      end else if (out_free) begin
         // The skid entry always drains first to keep order
         if (skid_valid) begin
            out_valid  <= 1'b1;
            skid_valid <= 1'b0;
         end else begin
            out_valid  <= in_valid;
         end
      end else if (in_valid && in_ready) begin
         // Output stalled, park the new beat in the second entry
         skid_valid <= 1'b1;
      end
   end

   // ========================================================================
   // Payload path
   // ========================================================================

   always_ff @(posedge clk) begin
      if (out_free) begin
         out_data <= skid_valid ? skid_data : in_data;
      end
      if (!out_free && in_ready) begin
         skid_data <= in_data;
      end
   end

endmodule

`default_nettype wire

// ==== hw/rx_a_classifier.sv ====
// ==========================================================================
// Decodes the header only on the start-of-packet beat. Later beats inherit
// the class; a commit is assumed to be a single beat.
// ==========================================================================
`default_nettype none

module rx_a_classifier (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  beat_valid,
   input  logic                  beat_ready,
   input  rx_chan_pkg::rx_beat_t beat,
   output logic                  is_cpl,
   output logic                  is_commit,
   output logic                  sop
);

   import tlp_hdr_pkg::*;

   // Header view of the current beat, only meaningful while sop is high
   cpl_hdr_t hdr;
   // Class of the packet in flight, kept for its non-SOP beats
   logic     is_cpl_q;
   // Header decode on the present beat
   logic     hdr_is_cpl;
   logic     hdr_has_data;
   // A beat moves on this cycle
   logic     xfer;

   assign hdr          = cpl_hdr_t'(beat.data);
   assign hdr_is_cpl   = is_completion(hdr.fmt_type);
   assign hdr_has_data = has_data(hdr.fmt_type);
   assign xfer         = beat_valid && beat_ready;

   // ========================================================================
   // Per-beat class
   // ========================================================================

   // On SOP the header decides; afterwards the stored class holds so that
   // payload bits that happen to look like a completion code don't matter
   assign is_cpl = sop ? hdr_is_cpl : is_cpl_q;

   // Commit has no data and only ever occupies the SOP beat
   assign is_commit = sop && hdr_is_cpl && !hdr_has_data;

   // ========================================================================
   // Packet boundary tracking
   // ========================================================================

   always_ff @(posedge clk) begin
      if (rst) begin
         // First beat after reset starts a packet
         sop      <= 1'b1;
         is_cpl_q <= 1'b0;
      end else if (xfer) begin
         // Next beat is a SOP exactly when this one was the last
         sop      <= beat.last;
         // Class drops back to idle once the packet ends
         is_cpl_q <= is_cpl && !beat.last;
      end
   end

endmodule

`default_nettype wire

// ==== hw/rx_port_demux.sv ====
// ==========================================================================
// RX-A stalls for any full destination its current class may go to. Stray
// completions on RX-A are dropped and flagged with unexpected_cpl.
// ==========================================================================
`default_nettype none

module rx_port_demux (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  port_rst,
   input  logic                  rx_a_valid,
   input  rx_chan_pkg::rx_beat_t rx_a_beat,
   output logic                  rx_a_ready,
   input  logic                  rx_b_valid,
   input  rx_chan_pkg::rx_beat_t rx_b_beat,
   output logic                  rx_b_ready,
   output logic                  mmio_valid,
   output rx_chan_pkg::rx_beat_t mmio_beat,
   input  logic                  mmio_ready,
   output logic                  cpl_valid,
   output rx_chan_pkg::rx_beat_t cpl_beat,
   input  logic                  cpl_ready,
   output logic                  commit_valid,
   output rx_chan_pkg::commit_t  commit,
   input  logic                  commit_ready,
   output logic                  unexpected_cpl
);

   import rx_chan_pkg::*;
   import tlp_hdr_pkg::*;

   localparam logic CPL_ON_A    = (CPL_CHAN == CHAN_A);
   localparam logic COMMIT_ON_A = (WR_COMMIT_CHAN == CHAN_A);

   // Port reset folds in the group reset
   logic     lrst;
   logic     a_sop;
   logic     a_is_cpl;
   logic     a_is_commit;
   logic     a_xfer;
   logic     mmio_in_ready;
   logic     cpl_in_ready;
   logic     commit_in_ready;
   // Sources selected for the completion and commit buffers
   logic     cpl_src_valid;
   rx_beat_t cpl_src_beat;
   logic     commit_src_valid;
   rx_beat_t commit_src_beat;
   cpl_hdr_t commit_src_hdr;
   commit_t  commit_in;
   logic     unexp_d;

   assign lrst = rst || port_rst;

   rx_a_classifier u_classifier (
      .clk        (clk),
      .rst        (lrst),
      .beat_valid (rx_a_valid),
      .beat_ready (rx_a_ready),
      .beat       (rx_a_beat),
      .is_cpl     (a_is_cpl),
      .is_commit  (a_is_commit),
      .sop        (a_sop)
   );

   // ========================================================================
   // Ready towards the PCIe side
   // ========================================================================

   // MMIO always counts, completion and commit buffers only when mapped to
   // RX-A and only for the class that would land there
   assign rx_a_ready = mmio_in_ready &&
                       (!CPL_ON_A || cpl_in_ready || !a_is_cpl || a_is_commit) &&
                       (!COMMIT_ON_A || commit_in_ready || !a_is_commit);

   // Ties high when neither class lives on RX-B
   assign rx_b_ready = (CPL_ON_A || cpl_in_ready) && (COMMIT_ON_A || commit_in_ready);

   // Buffer valids are gated by the full handshake so a beat held by a
   // different blocked destination is never taken twice
   assign a_xfer = rx_a_valid && rx_a_ready;

   // ========================================================================
   // Channel mapping
   // ========================================================================

   if (CPL_ON_A) begin : g_cpl_a
      assign cpl_src_valid = a_xfer && a_is_cpl && !a_is_commit;
      assign cpl_src_beat  = rx_a_beat;
   end else begin : g_cpl_b
      // Only completions travel on RX-B in this mapping
      assign cpl_src_valid = rx_b_valid && rx_b_ready;
      assign cpl_src_beat  = rx_b_beat;
   end

   if (COMMIT_ON_A) begin : g_commit_a
      assign commit_src_valid = a_xfer && a_is_commit;
      assign commit_src_beat  = rx_a_beat;
   end else begin : g_commit_b
      assign commit_src_valid = rx_b_valid && rx_b_ready;
      assign commit_src_beat  = rx_b_beat;
   end

   // Commit carries only the write's tag plus the sideband user bits
   assign commit_src_hdr = cpl_hdr_t'(commit_src_beat.data);
   assign commit_in.tag  = commit_src_hdr.tag;
   assign commit_in.user = commit_src_beat.user;

   // ========================================================================
   // Output buffers
   // ========================================================================

   rx_skid_buffer #(.payload_t(rx_beat_t)) u_mmio_skid (
      .clk       (clk),
      .rst       (lrst),
      .in_valid  (a_xfer && !a_is_cpl),
      .in_data   (rx_a_beat),
      .in_ready  (mmio_in_ready),
      .out_valid (mmio_valid),
      .out_data  (mmio_beat),
      .out_ready (mmio_ready)
   );

   rx_skid_buffer #(.payload_t(rx_beat_t)) u_cpl_skid (
      .clk       (clk),
      .rst       (lrst),
      .in_valid  (cpl_src_valid),
      .in_data   (cpl_src_beat),
      .in_ready  (cpl_in_ready),
      .out_valid (cpl_valid),
      .out_data  (cpl_beat),
      .out_ready (cpl_ready)
   );

   rx_skid_buffer #(.payload_t(commit_t)) u_commit_skid (
      .clk       (clk),
      .rst       (lrst),
      .in_valid  (commit_src_valid),
      .in_data   (commit_in),
      .in_ready  (commit_in_ready),
      .out_valid (commit_valid),
      .out_data  (commit),
      .out_ready (commit_ready)
   );

   // Completion on RX-A whose class is mapped to RX-B, flagged once per packet
   assign unexp_d = a_xfer && a_sop && a_is_cpl &&
                    (a_is_commit ? !COMMIT_ON_A : !CPL_ON_A);

   always_ff @(posedge clk) begin
      if (lrst) begin
         unexpected_cpl <= 1'b0;
      end else begin
         unexpected_cpl <= unexp_d;
      end
   end

endmodule

`default_nettype wire

// ==== hw/rx_demux_top.sv ====
// ==========================================================================
// One demux per port, no extra registers. Per-port signals are packed
// arrays indexed by port number.
// ==========================================================================
`default_nettype none

module rx_demux_top (
   input  logic                                                clk,
   input  logic                                                rst,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                   port_rst,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                   rx_a_valid,
   input  rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0]  rx_a_beat,
   output logic [rx_chan_pkg::NUM_PORTS-1:0]                   rx_a_ready,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                   rx_b_valid,
   input  rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0]  rx_b_beat,
   output logic [rx_chan_pkg::NUM_PORTS-1:0]                   rx_b_ready,
   output logic [rx_chan_pkg::NUM_PORTS-1:0]                   mmio_valid,
   output rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0]  mmio_beat,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                   mmio_ready,
   output logic [rx_chan_pkg::NUM_PORTS-1:0]                   cpl_valid,
   output rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0]  cpl_beat,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                   cpl_ready,
   output logic [rx_chan_pkg::NUM_PORTS-1:0]                   commit_valid,
   output rx_chan_pkg::commit_t [rx_chan_pkg::NUM_PORTS-1:0]   commit,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                   commit_ready,
   output logic [rx_chan_pkg::NUM_PORTS-1:0]                   unexpected_cpl
);

   import rx_chan_pkg::*;

   // Ports are fully independent, a port_rst touches only its own demux
   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
      rx_port_demux u_port (
         .clk            (clk),
         .rst            (rst),
         .port_rst       (port_rst[p]),
         .rx_a_valid     (rx_a_valid[p]),
         .rx_a_beat      (rx_a_beat[p]),
         .rx_a_ready     (rx_a_ready[p]),
         .rx_b_valid     (rx_b_valid[p]),
         .rx_b_beat      (rx_b_beat[p]),
         .rx_b_ready     (rx_b_ready[p]),
         .mmio_valid     (mmio_valid[p]),
         .mmio_beat      (mmio_beat[p]),
         .mmio_ready     (mmio_ready[p]),
         .cpl_valid      (cpl_valid[p]),
         .cpl_beat       (cpl_beat[p]),
         .cpl_ready      (cpl_ready[p]),
         .commit_valid   (commit_valid[p]),
         .commit         (commit[p]),
         .commit_ready   (commit_ready[p]),
         .unexpected_cpl (unexpected_cpl[p])
      );
   end

endmodule

`default_nettype wire

// ==== dv/rx_demux_checker.sv ====
// ==========================================================================
// Compares every output transfer with the beats accepted on RX-A and RX-B.
// Expects the fixed mapping with read completions on RX-A, commits on RX-B.
// ==========================================================================
`default_nettype none

module rx_demux_checker (
   input  logic                                               clk,
   input  logic                                               rst,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  port_rst,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  rx_a_valid,
   input  rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0] rx_a_beat,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  rx_a_ready,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  rx_b_valid,
   input  rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0] rx_b_beat,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  rx_b_ready,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  mmio_valid,
   input  rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0] mmio_beat,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  mmio_ready,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  cpl_valid,
   input  rx_chan_pkg::rx_beat_t [rx_chan_pkg::NUM_PORTS-1:0] cpl_beat,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  cpl_ready,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  commit_valid,
   input  rx_chan_pkg::commit_t [rx_chan_pkg::NUM_PORTS-1:0]  commit,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  commit_ready,
   input  logic [rx_chan_pkg::NUM_PORTS-1:0]                  unexpected_cpl,
   output int                                                 err_cnt,
   output int                                                 pending,
   output int                                                 xfer_cnt [6],
   output int                                                 pulse_cnt [2]
);

   timeunit 1ns;
   timeprecision 1ps;

   import rx_chan_pkg::*;
   import tlp_hdr_pkg::*;

   // Expected items of all streams, keyed by port * 3 + stream
   int              key_q[$];
   logic [80:0]     val_q[$];
   // Reference packet tracking for RX-A, one entry per port
   logic            sop [NUM_PORTS];
   int              cls [NUM_PORTS];
   logic            exp_pulse [NUM_PORTS];
   logic [7:0]      fmt;

   // Pops the oldest expected item of this port and stream and compares it
   task automatic take_output(input int port, input int stream, input string name,
                              input logic [80:0] act);
      int idx;
      idx = -1;
      for (int i = 0; i < key_q.size(); i++) begin
         if (idx < 0 && key_q[i] == port * 3 + stream) idx = i;
      end
      if (idx < 0) begin
         $display("%0t: ERROR %s[%0d] delivered a beat that no input produced",
                  $time, name, port);
         err_cnt++;
      end else begin
         if (val_q[idx] !== act) begin
            $display("MISMATCH %0t %s[%0d] expected %h actual %h",
                     $time, name, port, val_q[idx], act);
            err_cnt++;
         end
         key_q.delete(idx);
         val_q.delete(idx);
      end
      xfer_cnt[port * 3 + stream]++;
   endtask

   // ========================================================================
   // Edge sampling, all values read as they were before the edge
   // ========================================================================

   always @(posedge clk) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
         if (rst || port_rst[p]) begin
            sop[p]       = 1'b1;
            cls[p]       = 0;
            exp_pulse[p] = 1'b0;
            // Beats still queued for this port are lost with its buffers
            for (int i = key_q.size() - 1; i >= 0; i--) begin
               if (key_q[i] / 3 == p) begin
                  key_q.delete(i);
                  val_q.delete(i);
               end
            end
         end else begin
            // The pulse must follow the dropped beat by exactly one cycle
            if (unexpected_cpl[p] !== exp_pulse[p]) begin
               $display("MISMATCH %0t unexpected_cpl[%0d] expected %b actual %b",
                        $time, p, exp_pulse[p], unexpected_cpl[p]);
               err_cnt++;
            end
            if (unexpected_cpl[p] === 1'b1) pulse_cnt[p]++;
            exp_pulse[p] = 1'b0;
            if (mmio_valid[p] && mmio_ready[p]) take_output(p, 0, "mmio_beat", mmio_beat[p]);
            if (cpl_valid[p] && cpl_ready[p]) take_output(p, 1, "cpl_beat", cpl_beat[p]);
            if (commit_valid[p] && commit_ready[p]) begin
               take_output(p, 2, "commit", 81'(commit[p]));
            end
            if (rx_a_valid[p] && rx_a_ready[p]) begin
               // Header byte decides on the first beat only, class 3 is the drop
               if (sop[p]) begin
                  fmt = rx_a_beat[p].data[63:56];
                  if (fmt == FMT_CPL) cls[p] = 3;
                  else if (fmt == FMT_CPLD) cls[p] = 1;
                  else cls[p] = 0;
                  if (cls[p] == 3) exp_pulse[p] = 1'b1;
               end
               if (cls[p] != 3) begin
                  key_q.push_back(p * 3 + cls[p]);
                  val_q.push_back(rx_a_beat[p]);
               end
               sop[p] = rx_a_beat[p].last;
            end
            if (rx_b_valid[p] && rx_b_ready[p]) begin
               // Tag sits right below the format byte of the header
               key_q.push_back(p * 3 + 2);
               val_q.push_back(81'({rx_b_beat[p].data[55:46], rx_b_beat[p].user}));
            end
         end
      end
      pending = key_q.size();
   end

endmodule

`default_nettype wire

// ==== dv/rx_demux_tb.sv ====
// ==========================================================================
// Packet table applied one entry at a time. Output ready is random from a
// fixed seed, except where a test holds cpl_ready low.
// ==========================================================================
`default_nettype none

module rx_demux_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import rx_chan_pkg::*;
   import tlp_hdr_pkg::*;

   localparam int NUM_TESTS = 13;
   // Test kinds: plain packet, packet under a cpl stall, port reset
   localparam logic [1:0] K_PKT = 2'd0, K_STALL = 2'd1, K_PRST = 2'd2;
   // Streams as the checker numbers them, 3 means nothing comes out
   localparam logic [1:0] S_MMIO = 2'd0, S_CPL = 2'd1, S_COMMIT = 2'd2, S_NONE = 2'd3;

   typedef struct packed {
      logic [1:0] kind;
      logic       port;
      logic       chan;
      fmt_type_t  fmt;
      logic [9:0] tag;
      logic [3:0] beats;
      logic [7:0] seed;
      logic [1:0] stream;
      logic [1:0] unexp;
   } test_t;

   logic                           clk;
   logic                           rst;
   logic     [NUM_PORTS-1:0]       port_rst;
   logic     [NUM_PORTS-1:0]       rx_a_valid, rx_a_ready, rx_b_valid, rx_b_ready;
   rx_beat_t [NUM_PORTS-1:0]       rx_a_beat, rx_b_beat, mmio_beat, cpl_beat;
   logic     [NUM_PORTS-1:0]       mmio_valid, mmio_ready, cpl_valid, cpl_ready;
   logic     [NUM_PORTS-1:0]       commit_valid, commit_ready, unexpected_cpl;
   commit_t  [NUM_PORTS-1:0]       commit;
   int                             chk_err, pending;
   int                             xfer_cnt [6];
   int                             pulse_cnt [2];
   test_t                          tests [NUM_TESTS];
   integer                         seed = 38;
   int                             rnd, errors, limit, tp, base [6], base_pulse, want;
   logic                           hold_cpl, test_ok;

   rx_demux_top u_dut (.*);

   rx_demux_checker u_chk (.*, .err_cnt(chk_err));

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // Random back-pressure, ready high three times out of four
   always @(posedge clk) begin
      rnd = $random(seed);
      mmio_ready   <= {rnd[1:0] != 2'd0, rnd[3:2] != 2'd0};
      cpl_ready    <= hold_cpl ? '0 : {rnd[5:4] != 2'd0, rnd[7:6] != 2'd0};
      commit_ready <= {rnd[9:8] != 2'd0, rnd[11:10] != 2'd0};
   end

   // Later beats carry a completion code on top to show it is ignored
   function automatic rx_beat_t make_beat(input fmt_type_t fmt, input logic [9:0] tag,
                                          input int beats, input logic [7:0] sd, input int i);
      rx_beat_t b;
      b.last = (i == beats - 1);
      b.user = sd + 8'(i);
      b.keep = 8'hff;
      if (i == 0) b.data = {fmt, tag, 10'(beats), 28'h0, sd};
      else b.data = {(i % 2) ? FMT_CPLD : FMT_CPL, 48'h0, sd + 8'(i)};
      return b;
   endfunction

   task automatic send_packet(input int port, input logic chan, input fmt_type_t fmt,
                              input logic [9:0] tag, input int beats, input logic [7:0] sd);
      @(posedge clk);
      for (int i = 0; i < beats; i++) begin
         if (chan == CHAN_A) begin
            rx_a_valid[port] <= 1'b1;
            rx_a_beat[port]  <= make_beat(fmt, tag, beats, sd, i);
            do @(posedge clk); while (!rx_a_ready[port]);
         end else begin
            rx_b_valid[port] <= 1'b1;
            rx_b_beat[port]  <= make_beat(fmt, tag, beats, sd, i);
            do @(posedge clk); while (!rx_b_ready[port]);
         end
      end
      rx_a_valid[port] <= 1'b0;
      rx_b_valid[port] <= 1'b0;
   endtask

   task automatic check_idle(input int port, input string what);
      if (mmio_valid[port] !== 1'b0 || cpl_valid[port] !== 1'b0 ||
          commit_valid[port] !== 1'b0 || unexpected_cpl[port] !== 1'b0 ||
          rx_a_ready[port] !== 1'b1 || rx_b_ready[port] !== 1'b1) begin
         $display("%0t: ERROR port %0d is not idle after %s", $time, port, what);
         errors++;
      end
   endtask

   initial begin
      rst = 1'b1;
      port_rst = '0;
      rx_a_valid = '0;
      rx_b_valid = '0;
      rx_a_beat = '0;
      rx_b_beat = '0;
      mmio_ready = '0;
      cpl_ready = '0;
      commit_ready = '0;
      hold_cpl = 1'b0;
      errors = 0;
      tests[0]  = '{K_PKT,   1'b0, CHAN_A, FMT_MRD,  10'h005, 4'd1, 8'h11, S_MMIO,   2'd0};
      tests[1]  = '{K_PKT,   1'b0, CHAN_A, FMT_MWR,  10'h006, 4'd4, 8'h22, S_MMIO,   2'd0};
      tests[2]  = '{K_PKT,   1'b1, CHAN_A, FMT_MRD,  10'h007, 4'd1, 8'h33, S_MMIO,   2'd0};
      tests[3]  = '{K_PKT,   1'b1, CHAN_A, FMT_CPLD, 10'h008, 4'd3, 8'h44, S_CPL,    2'd0};
      tests[4]  = '{K_PKT,   1'b0, CHAN_A, FMT_CPLD, 10'h009, 4'd2, 8'h55, S_CPL,    2'd0};
      tests[5]  = '{K_PKT,   1'b0, CHAN_B, FMT_CPL,  10'h155, 4'd1, 8'h66, S_COMMIT, 2'd0};
      tests[6]  = '{K_PKT,   1'b1, CHAN_B, FMT_CPL,  10'h2aa, 4'd1, 8'h77, S_COMMIT, 2'd0};
      tests[7]  = '{K_STALL, 1'b0, CHAN_A, FMT_CPLD, 10'h010, 4'd6, 8'h88, S_CPL,    2'd0};
      tests[8]  = '{K_PKT,   1'b0, CHAN_A, FMT_MWR,  10'h011, 4'd3, 8'h99, S_MMIO,   2'd0};
      tests[9]  = '{K_PKT,   1'b0, CHAN_A, FMT_CPL,  10'h012, 4'd1, 8'haa, S_NONE,   2'd1};
      // Resets port 0 while the packet runs on port 1
      tests[10] = '{K_PRST,  1'b0, CHAN_A, FMT_MWR,  10'h013, 4'd4, 8'hbb, S_MMIO,   2'd0};
      tests[11] = '{K_PKT,   1'b0, CHAN_A, FMT_CPLD, 10'h014, 4'd2, 8'hcc, S_CPL,    2'd0};
      tests[12] = '{K_PKT,   1'b1, CHAN_B, FMT_CPL,  10'h015, 4'd1, 8'hdd, S_COMMIT, 2'd0};

      // ======================================================================
      // Watchdog sized from the table
      // ======================================================================
      limit = 2;
      for (int t = 0; t < NUM_TESTS; t++) limit += 20 * int'(tests[t].beats);
      fork
         begin
            repeat (limit) @(posedge clk);
            $display("%0t: ERROR run timed out after %0d cycles", $time, limit);
            $display("TEST RESULT: FAIL");
            $finish;
         end
      join_none

      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_idle(0, "rst");
      check_idle(1, "rst");

      // ======================================================================
      // Table loop
      // ======================================================================
      for (int t = 0; t < NUM_TESTS; t++) begin
         tp = (tests[t].kind == K_PRST) ? int'(!tests[t].port) : int'(tests[t].port);
         for (int k = 0; k < 6; k++) base[k] = xfer_cnt[k];
         base_pulse = pulse_cnt[tp];
         test_ok = 1'b1;
         if (tests[t].kind == K_PKT) begin
            send_packet(tp, tests[t].chan, tests[t].fmt, tests[t].tag,
                        tests[t].beats, tests[t].seed);
         end else if (tests[t].kind == K_STALL) begin
            hold_cpl <= 1'b1;
            repeat (2) @(posedge clk);
            fork
               send_packet(tp, tests[t].chan, tests[t].fmt, tests[t].tag,
                           tests[t].beats, tests[t].seed);
               begin
                  repeat (25) @(posedge clk);
                  // Two beats fill the buffer, the third must be held on RX-A
                  if (!rx_a_valid[tp] || rx_a_ready[tp] || !cpl_valid[tp]) begin
                     $display("%0t: ERROR RX-A did not stall while cpl_ready was low",
                              $time);
                     test_ok = 1'b0;
                  end
                  hold_cpl <= 1'b0;
               end
            join
         end else begin
            fork
               send_packet(tp, tests[t].chan, tests[t].fmt, tests[t].tag,
                           tests[t].beats, tests[t].seed);
               begin
                  // Park completion beats in the reset port so the reset has state to clear
                  hold_cpl <= 1'b1;
                  @(posedge clk);
                  rx_a_valid[tests[t].port] <= 1'b1;
                  rx_a_beat[tests[t].port]  <= make_beat(FMT_CPLD, tests[t].tag, 3,
                                                         tests[t].seed, 0);
                  repeat (4) @(posedge clk);
                  rx_a_valid[tests[t].port] <= 1'b0;
                  port_rst[tests[t].port]   <= 1'b1;
                  repeat (2) @(posedge clk);
                  port_rst[tests[t].port] <= 1'b0;
                  hold_cpl <= 1'b0;
                  @(posedge clk);
                  check_idle(tests[t].port, "port_rst");
               end
            join
         end
         // Counters settle on the rising edge, so they are read on the falling one
         @(negedge clk);
         while (pending != 0) @(negedge clk);
         repeat (3) @(negedge clk);
         // Every beat on the expected stream, nothing on the others
         for (int s = 0; s < 3; s++) begin
            want = (s != tests[t].stream) ? 0 : (s == 2) ? 1 : int'(tests[t].beats);
            if (xfer_cnt[tp * 3 + s] - base[tp * 3 + s] != want) test_ok = 1'b0;
         end
         if (pulse_cnt[tp] - base_pulse != int'(tests[t].unexp)) test_ok = 1'b0;
         if (!test_ok) errors++;
         $display("test %0d port %0d kind %0d: %s", t, tp, tests[t].kind,
                  test_ok ? "ok" : "wrong number of beats or pulses");
      end

      $display("tests %0d, test errors %0d, checker errors %0d", NUM_TESTS, errors, chk_err);
      if (errors == 0 && chk_err == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
hw/tlp_hdr_pkg.sv
hw/rx_chan_pkg.sv
hw/rx_skid_buffer.sv
hw/rx_a_classifier.sv
hw/rx_port_demux.sv
hw/rx_demux_top.sv
dv/rx_demux_checker.sv
dv/rx_demux_tb.sv

// ==== Bender.yml ====
package:
  name: rx_demux

sources:
  - files:
      - hw/tlp_hdr_pkg.sv
      - hw/rx_chan_pkg.sv
      - hw/rx_skid_buffer.sv
      - hw/rx_a_classifier.sv
      - hw/rx_port_demux.sv
      - hw/rx_demux_top.sv
  - target: simulation
    files:
      - dv/rx_demux_checker.sv
      - dv/rx_demux_tb.sv
